//--- include/la32_macros.svh
`ifndef LA32_MACROS_SVH
`define LA32_MACROS_SVH

`define LA32_RESET_PC 32'h1c00_0000
`define LA32_XLEN     32
`define LA32_NREGS    32

// 3R and 2RI5 forms, matched on inst[31:15].
`define LA32_OP_ADD_W  17'h00020
`define LA32_OP_SUB_W  17'h00022
`define LA32_OP_SLT    17'h00024
`define LA32_OP_SLTU   17'h00025
`define LA32_OP_NOR    17'h00028
`define LA32_OP_AND    17'h00029
`define LA32_OP_OR     17'h0002a
`define LA32_OP_XOR    17'h0002b
`define LA32_OP_SLLI_W 17'h00081
`define LA32_OP_SRLI_W 17'h00089
`define LA32_OP_SRAI_W 17'h00091

// 2RI12 forms, matched on inst[31:22].
`define LA32_OP_ADDI_W 10'h00a
`define LA32_OP_LD_W   10'h0a2
`define LA32_OP_ST_W   10'h0a6

`define LA32_OP_LU12I_W 7'h0a // inst[31:25].

// Jumps and branches, matched on inst[31:26].
`define LA32_OP_JIRL 6'h13
`define LA32_OP_B    6'h14
`define LA32_OP_BL   6'h15
`define LA32_OP_BEQ  6'h16
`define LA32_OP_BNE  6'h17

`endif

//--- hdl/la32_pkg.sv
`default_nettype none

package la32_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_UI5,
        IMM_SI12,
        IMM_SI16,
        IMM_SI20,
        IMM_SI26,
        IMM_FOUR
    } imm_kind_t;

    typedef enum logic [2:0] {
        S_IF,
        S_ID,
        S_EXE,
        S_MEM,
        S_WB
    } state_t;

endpackage

`default_nettype wire

//--- hdl/la32_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_decoder (
    input  wire logic [`LA32_XLEN-1:0] inst,
    output la32_pkg::alu_op_t          alu_op,
    output logic                       src1_is_pc,
    output logic                       src2_is_imm,
    output logic                       src_reg_is_rd,
    output logic [`LA32_XLEN-1:0]      imm,
    output logic [`LA32_XLEN-1:0]      br_offs,
    output logic                       is_load,
    output logic                       is_store,
    output logic                       is_jirl,
    output logic                       is_bl,
    output logic                       is_b,
    output logic                       is_beq,
    output logic                       is_bne,
    output logic                       gr_we,
    output logic [4:0]                 dest
);

    logic is_add, is_sub, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
    logic is_slli, is_srli, is_srai, is_addi, is_lu12i;
    logic is_shift, is_valid;
    la32_pkg::imm_kind_t imm_kind;
    la32_pkg::imm_kind_t br_kind;

    // Branch offsets come back already scaled by 4.
    function automatic logic [`LA32_XLEN-1:0] ext_imm(la32_pkg::imm_kind_t kind,
                                                      logic [`LA32_XLEN-1:0] ins);
        case (kind)
            la32_pkg::IMM_UI5:  return {27'b0, ins[14:10]};
            la32_pkg::IMM_SI16: return {{14{ins[25]}}, ins[25:10], 2'b00};
            la32_pkg::IMM_SI20: return {ins[24:5], 12'b0};
            la32_pkg::IMM_SI26: return {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
            la32_pkg::IMM_FOUR: return 32'd4;
            default:            return {{20{ins[21]}}, ins[21:10]};
        endcase
    endfunction

    assign is_add   = inst[31:15] == `LA32_OP_ADD_W;
    assign is_sub   = inst[31:15] == `LA32_OP_SUB_W;
    assign is_slt   = inst[31:15] == `LA32_OP_SLT;
    assign is_sltu  = inst[31:15] == `LA32_OP_SLTU;
    assign is_nor   = inst[31:15] == `LA32_OP_NOR;
    assign is_and   = inst[31:15] == `LA32_OP_AND;
    assign is_or    = inst[31:15] == `LA32_OP_OR;
    assign is_xor   = inst[31:15] == `LA32_OP_XOR;
    assign is_slli  = inst[31:15] == `LA32_OP_SLLI_W;
    assign is_srli  = inst[31:15] == `LA32_OP_SRLI_W;
    assign is_srai  = inst[31:15] == `LA32_OP_SRAI_W;
    assign is_addi  = inst[31:22] == `LA32_OP_ADDI_W;
    assign is_load  = inst[31:22] == `LA32_OP_LD_W;
    assign is_store = inst[31:22] == `LA32_OP_ST_W;
    assign is_lu12i = inst[31:25] == `LA32_OP_LU12I_W;
    assign is_jirl  = inst[31:26] == `LA32_OP_JIRL;
    assign is_b     = inst[31:26] == `LA32_OP_B;
    assign is_bl    = inst[31:26] == `LA32_OP_BL;
    assign is_beq   = inst[31:26] == `LA32_OP_BEQ;
    assign is_bne   = inst[31:26] == `LA32_OP_BNE;

    assign is_shift = is_slli | is_srli | is_srai;
    assign is_valid = is_add | is_sub | is_slt | is_sltu | is_nor | is_and | is_or | is_xor
                    | is_shift | is_addi | is_load | is_store | is_lu12i
                    | is_jirl | is_b | is_bl | is_beq | is_bne;

    always_comb begin
        alu_op = la32_pkg::ALU_ADD; // Address and link adds too.
        if (is_sub)        alu_op = la32_pkg::ALU_SUB;
        else if (is_slt)   alu_op = la32_pkg::ALU_SLT;
        else if (is_sltu)  alu_op = la32_pkg::ALU_SLTU;
        else if (is_and)   alu_op = la32_pkg::ALU_AND;
        else if (is_nor)   alu_op = la32_pkg::ALU_NOR;
        else if (is_or)    alu_op = la32_pkg::ALU_OR;
        else if (is_xor)   alu_op = la32_pkg::ALU_XOR;
        else if (is_slli)  alu_op = la32_pkg::ALU_SLL;
        else if (is_srli)  alu_op = la32_pkg::ALU_SRL;
        else if (is_srai)  alu_op = la32_pkg::ALU_SRA;
        else if (is_lu12i) alu_op = la32_pkg::ALU_LUI;
    end

    always_comb begin
        imm_kind = la32_pkg::IMM_SI12;
        if (is_shift)              imm_kind = la32_pkg::IMM_UI5;
        else if (is_lu12i)         imm_kind = la32_pkg::IMM_SI20;
        else if (is_jirl | is_bl)  imm_kind = la32_pkg::IMM_FOUR;
    end

    assign br_kind = (is_b | is_bl) ? la32_pkg::IMM_SI26 : la32_pkg::IMM_SI16;

    assign imm     = ext_imm(imm_kind, inst);
    assign br_offs = ext_imm(br_kind, inst);

    assign src1_is_pc    = is_jirl | is_bl;
    assign src2_is_imm   = is_shift | is_addi | is_load | is_store | is_lu12i | is_jirl | is_bl;
    assign src_reg_is_rd = is_beq | is_bne | is_store;

    assign gr_we = is_valid & ~is_store & ~is_b & ~is_beq & ~is_bne;
    assign dest  = is_bl ? 5'd1 : inst[4:0]; // bl links through r1.

endmodule

`default_nettype wire

//--- hdl/la32_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_alu (
    input  la32_pkg::alu_op_t          alu_op,
    input  wire logic [`LA32_XLEN-1:0] alu_src1,
    input  wire logic [`LA32_XLEN-1:0] alu_src2,
    output logic [`LA32_XLEN-1:0]      alu_result
);

    logic [4:0]            sa;
    logic [`LA32_XLEN-1:0] diff;

    assign sa   = alu_src2[4:0];
    assign diff = alu_src1 - alu_src2;

    always_comb begin
        case (alu_op)
            la32_pkg::ALU_ADD:  alu_result = alu_src1 + alu_src2;
            la32_pkg::ALU_SUB:  alu_result = diff;
            la32_pkg::ALU_SLT:
                alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            la32_pkg::ALU_SLTU: alu_result = {31'b0, alu_src1 < alu_src2};
            la32_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            la32_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            la32_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            la32_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            la32_pkg::ALU_SLL:  alu_result = alu_src1 << sa;
            la32_pkg::ALU_SRL:  alu_result = alu_src1 >> sa;
            la32_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_src1) >>> sa);
            la32_pkg::ALU_LUI:  alu_result = alu_src2; // Already shifted by the decoder.
            default:            alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/la32_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_regfile (
    input  wire logic                  clk,
    input  wire logic [4:0]            raddr1,
    input  wire logic [4:0]            raddr2,
    input  wire logic                  we,
    input  wire logic [4:0]            waddr,
    input  wire logic [`LA32_XLEN-1:0] wdata,
    output logic [`LA32_XLEN-1:0]      rdata1,
    output logic [`LA32_XLEN-1:0]      rdata2
);

    logic [`LA32_XLEN-1:0] regs [`LA32_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0)
            regs[waddr] <= wdata;
    end

    // r0 reads as zero whatever the array holds.
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/mycpu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module mycpu_top (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output logic [`LA32_XLEN-1:0]      inst_sram_addr,
    input  wire logic [`LA32_XLEN-1:0] inst_sram_rdata,
    output logic                       data_sram_we,
    output logic [`LA32_XLEN-1:0]      data_sram_addr,
    output logic [`LA32_XLEN-1:0]      data_sram_wdata,
    input  wire logic [`LA32_XLEN-1:0] data_sram_rdata,
    output logic [`LA32_XLEN-1:0]      debug_wb_pc,
    output logic [3:0]                 debug_wb_rf_we,
    output logic [4:0]                 debug_wb_rf_wnum,
    output logic [`LA32_XLEN-1:0]      debug_wb_rf_wdata
);

    la32_pkg::state_t state, next_state;

    logic [`LA32_XLEN-1:0] pc;
    logic [`LA32_XLEN-1:0] inst;
    logic [`LA32_XLEN-1:0] rj_value, rkd_value;
    logic [`LA32_XLEN-1:0] alu_src1, alu_src2;
    logic [`LA32_XLEN-1:0] alu_result, alu_result_q;
    logic [`LA32_XLEN-1:0] final_result;

    la32_pkg::alu_op_t     alu_op;
    logic                  src1_is_pc, src2_is_imm, src_reg_is_rd;
    logic [`LA32_XLEN-1:0] imm, br_offs;
    logic                  is_load, is_store, is_jirl, is_bl, is_b, is_beq, is_bne;
    logic                  gr_we;
    logic [4:0]            dest;

    logic [4:0]            rf_raddr1, rf_raddr2;
    logic [`LA32_XLEN-1:0] rf_rdata1, rf_rdata2;
    logic                  rf_we;

    logic                  is_branch, br_taken;
    logic [`LA32_XLEN-1:0] seq_pc, br_target;

    la32_decoder u_decoder (
        .inst          (inst),
        .alu_op        (alu_op),
        .src1_is_pc    (src1_is_pc),
        .src2_is_imm   (src2_is_imm),
        .src_reg_is_rd (src_reg_is_rd),
        .imm           (imm),
        .br_offs       (br_offs),
        .is_load       (is_load),
        .is_store      (is_store),
        .is_jirl       (is_jirl),
        .is_bl         (is_bl),
        .is_b          (is_b),
        .is_beq        (is_beq),
        .is_bne        (is_bne),
        .gr_we         (gr_we),
        .dest          (dest)
    );

    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = src_reg_is_rd ? inst[4:0] : inst[14:10];
    assign rf_we     = (state == la32_pkg::S_WB) && gr_we && (dest != 5'd0);

    la32_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (final_result),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    la32_alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    // Conditional branches resolve in ID on the live register reads.
    assign is_branch = is_b | is_beq | is_bne;
    assign br_taken  = is_b
                     | (is_beq && rf_rdata1 == rf_rdata2)
                     | (is_bne && rf_rdata1 != rf_rdata2);
    assign seq_pc    = pc + 32'd4;
    assign br_target = pc + br_offs;

    always_comb begin
        case (state)
            la32_pkg::S_IF:  next_state = la32_pkg::S_ID;
            la32_pkg::S_ID:  next_state = is_branch ? la32_pkg::S_IF : la32_pkg::S_EXE;
            la32_pkg::S_EXE: next_state = (is_load | is_store) ? la32_pkg::S_MEM : la32_pkg::S_WB;
            la32_pkg::S_MEM: next_state = is_load ? la32_pkg::S_WB : la32_pkg::S_IF;
            default:         next_state = la32_pkg::S_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= la32_pkg::S_IF;
            pc    <= `LA32_RESET_PC;
        end else begin
            state <= next_state;
            if (state == la32_pkg::S_ID && is_branch)
                pc <= br_taken ? br_target : seq_pc;
            else if (state == la32_pkg::S_MEM && is_store)
                pc <= seq_pc; // Stores never reach WB.
            else if (state == la32_pkg::S_WB) begin
                if (is_jirl)
                    pc <= rj_value + br_offs;
                else if (is_bl)
                    pc <= br_target;
                else
                    pc <= seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            la32_pkg::S_IF: inst <= inst_sram_rdata;
            la32_pkg::S_ID: begin
                rj_value  <= rf_rdata1;
                rkd_value <= rf_rdata2;
                alu_src1  <= src1_is_pc ? pc : rf_rdata1;
                alu_src2  <= src2_is_imm ? imm : rf_rdata2;
            end
            la32_pkg::S_EXE: begin
                alu_result_q <= alu_result;
                final_result <= alu_result;
            end
            la32_pkg::S_MEM: begin
                if (is_load)
                    final_result <= data_sram_rdata;
            end
            default: ;
        endcase
    end

    assign inst_sram_addr  = pc;
    assign data_sram_we    = (state == la32_pkg::S_MEM) && is_store;
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = rkd_value;

    // Trace follows the regfile write exactly.
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

`default_nettype wire

//--- test/mycpu_props.sv
`timescale 1ns/100ps
`default_nettype none

module la32_props (
    input wire logic        clk,
    input wire logic        reset,
    input la32_pkg::state_t state,
    input wire logic        data_sram_we,
    input wire logic [3:0]  debug_wb_rf_we
);

    a_we_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> state == la32_pkg::S_MEM)
        else $error("data_sram_we high outside MEM");

    a_trace_in_wb: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we != 4'h0 |-> state == la32_pkg::S_WB)
        else $error("debug_wb_rf_we set outside WB");

    a_wb_then_if: assert property (@(posedge clk) disable iff (reset)
        state == la32_pkg::S_WB |=> state == la32_pkg::S_IF)
        else $error("WB not followed by IF");

    // Reset leaves the FSM in IF.
    a_reset_if: assert property (@(posedge clk) $fell(reset) |-> state == la32_pkg::S_IF)
        else $error("state not IF after reset");

endmodule

bind mycpu_top la32_props u_props (
    .clk            (clk),
    .reset          (reset),
    .state          (state),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we)
);

`default_nettype wire

//--- test/mycpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module mycpu_tb;

    logic clk, reset;
    logic [31:0] inst_sram_addr, inst_sram_rdata, data_sram_addr, data_sram_wdata;
    logic [31:0] data_sram_rdata, debug_wb_pc, debug_wb_rf_wdata;
    logic        data_sram_we;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] inst_off;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] ref_dmem [64];
    logic [31:0] sh [`LA32_NREGS]; // Shadow registers.
    logic [31:0] prog [$];
    logic [31:0] ref_pc;
    logic [31:0] lfsr;
    bit          first;

    mycpu_top dut (.*);

    always #20 clk = ~clk;

    assign inst_off        = (inst_sram_addr - `LA32_RESET_PC) >> 2;
    assign inst_sram_rdata = imem[inst_off[5:0]];
    assign data_sram_rdata = dmem[data_sram_addr[7:2]];

    always @(posedge clk) begin
        if (data_sram_we)
            dmem[data_sram_addr[7:2]] <= data_sram_wdata;
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_3r(logic [16:0] op, logic [4:0] rd, logic [4:0] rj,
                                           logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(logic [9:0] op, logic [4:0] rd, logic [4:0] rj,
                                            logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_br(logic [5:0] op, logic [4:0] rd, logic [4:0] rj,
                                           logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_br26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic emit(logic [31:0] w);
        prog.push_back(w);
    endtask

    // Loads the queued program and pulses reset.
    task automatic start_prog();
        foreach (imem[i])
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0; // Zero decodes as a no-op.
        prog.delete();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        ref_pc = `LA32_RESET_PC;
        first  = 1'b1;
    endtask

    // Architectural meaning of one instruction.
    task automatic ref_step(output logic wr, output logic [4:0] wn, output logic [31:0] wd,
                            output int cyc);
        logic [31:0] i, off, a, b, d, si12, o16, o26, npc, adr;
        off  = (ref_pc - `LA32_RESET_PC) >> 2;
        i    = imem[off[5:0]];
        a    = sh[i[9:5]];
        b    = sh[i[14:10]];
        d    = sh[i[4:0]];
        si12 = {{20{i[21]}}, i[21:10]};
        o16  = {{14{i[25]}}, i[25:10], 2'b00};
        o26  = {{4{i[9]}}, i[9:0], i[25:10], 2'b00};
        adr  = a + si12;
        wr   = 1'b1;
        wn   = i[4:0];
        wd   = '0;
        cyc  = 4;
        npc  = ref_pc + 32'd4;
        case (i[31:15])
            `LA32_OP_ADD_W:  wd = a + b;
            `LA32_OP_SUB_W:  wd = a - b;
            `LA32_OP_SLT:    wd = {31'b0, $signed(a) < $signed(b)};
            `LA32_OP_SLTU:   wd = {31'b0, a < b};
            `LA32_OP_NOR:    wd = ~(a | b);
            `LA32_OP_AND:    wd = a & b;
            `LA32_OP_OR:     wd = a | b;
            `LA32_OP_XOR:    wd = a ^ b;
            `LA32_OP_SLLI_W: wd = a << i[14:10];
            `LA32_OP_SRLI_W: wd = a >> i[14:10];
            `LA32_OP_SRAI_W: wd = $unsigned($signed(a) >>> i[14:10]);
            default: begin
                case (i[31:22])
                    `LA32_OP_ADDI_W: wd = adr;
                    `LA32_OP_LD_W: begin
                        wd  = ref_dmem[adr[7:2]];
                        cyc = 5;
                    end
                    `LA32_OP_ST_W: begin
                        ref_dmem[adr[7:2]] = d;
                        wr = 1'b0;
                    end
                    default: begin
                        if (i[31:25] == `LA32_OP_LU12I_W)
                            wd = {i[24:5], 12'b0};
                        else begin
                            case (i[31:26])
                                `LA32_OP_JIRL: begin
                                    wd  = ref_pc + 32'd4;
                                    npc = a + o16;
                                end
                                `LA32_OP_BL: begin
                                    wn  = 5'd1;
                                    wd  = ref_pc + 32'd4;
                                    npc = ref_pc + o26;
                                end
                                `LA32_OP_B:   npc = ref_pc + o26;
                                `LA32_OP_BEQ: npc = (a == d) ? ref_pc + o16 : npc;
                                `LA32_OP_BNE: npc = (a != d) ? ref_pc + o16 : npc;
                                default: ;
                            endcase
                            if (i[31:26] inside {`LA32_OP_B, `LA32_OP_BEQ, `LA32_OP_BNE}) begin
                                wr  = 1'b0;
                                cyc = 2;
                            end else if (i[31:26] != `LA32_OP_JIRL && i[31:26] != `LA32_OP_BL)
                                wr = 1'b0; // Undefined encoding.
                        end
                    end
                endcase
            end
        endcase
        wr = wr && (wn != 5'd0);
        if (wr)
            sh[wn] = wd;
        ref_pc = npc;
    endtask

    // Predicts the next write-back, waits for it and compares.
    task automatic expect_wb();
        logic        wr;
        logic [4:0]  wn;
        logic [31:0] wd, wpc;
        int          cyc, total, waited;
        wr    = 1'b0;
        total = 0;
        for (int n = 0; !wr; n++) begin
            if (n == 64)
                abort_run("Reference model found no register write in the program");
            wpc = ref_pc;
            ref_step(wr, wn, wd, cyc);
            total += cyc;
        end
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 100)
                abort_run("Timed out waiting for a register write-back");
        end while (debug_wb_rf_we == 4'h0);
        check("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'hf);
        check("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, {27'b0, wn});
        check("debug_wb_rf_wdata", debug_wb_rf_wdata, wd);
        check("debug_wb_pc", debug_wb_pc, wpc);
        if (!first)
            check("cycles between write-backs", waited, total);
        first = 1'b0;
    endtask

    task automatic load_const(logic [4:0] rd);
        emit({`LA32_OP_LU12I_W, 20'(rand_bits(20)), rd});
        emit(enc_i12(`LA32_OP_ADDI_W, rd, rd, 12'(rand_bits(12))));
    endtask

    task automatic test_alu();
        logic [16:0] ops [8];
        ops = '{`LA32_OP_ADD_W, `LA32_OP_SUB_W, `LA32_OP_SLT, `LA32_OP_SLTU,
                `LA32_OP_NOR, `LA32_OP_AND, `LA32_OP_OR, `LA32_OP_XOR};
        for (int round = 0; round < 2; round++) begin
            load_const(5'd4);
            load_const(5'd5);
            for (int k = 0; k < 8; k++)
                emit(enc_3r(ops[k], 5'(6 + k), 5'd4, 5'd5));
            emit(enc_3r(`LA32_OP_SLLI_W, 5'd14, 5'd4, 5'(rand_bits(5))));
            emit(enc_3r(`LA32_OP_SRLI_W, 5'd15, 5'd4, 5'(rand_bits(5))));
            emit(enc_3r(`LA32_OP_SRAI_W, 5'd16, 5'd4, 5'(rand_bits(5))));
            emit(enc_i12(`LA32_OP_ADDI_W, 5'd17, 5'd5, 12'(rand_bits(12))));
            start_prog();
            repeat (16) expect_wb();
        end
    endtask

    task automatic test_mem();
        logic [11:0] offs [3];
        for (int k = 0; k < 3; k++) begin
            offs[k] = {5'b0, 5'(rand_bits(5)), 2'b00} + 12'd4;
            load_const(5'd4);
            emit(enc_i12(`LA32_OP_ST_W, 5'd4, 5'd0, offs[k]));
            emit(enc_i12(`LA32_OP_LD_W, 5'(9 + k), 5'd0, offs[k]));
        end
        start_prog();
        repeat (9) expect_wb();
        for (int k = 0; k < 3; k++)
            check("dmem", dmem[offs[k][7:2]], ref_dmem[offs[k][7:2]]);
    endtask

    task automatic test_branch();
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd4, 5'd0, 12'd5));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd5, 5'd0, 12'd5));
        emit(enc_br(`LA32_OP_BEQ, 5'd5, 5'd4, 16'd2)); // Taken.
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd6, 5'd0, 12'd1));
        emit(enc_br(`LA32_OP_BNE, 5'd5, 5'd4, 16'd2));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd7, 5'd0, 12'd2));
        emit(enc_br26(`LA32_OP_B, 26'd2));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd6, 5'd0, 12'd3));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd8, 5'd0, 12'd4));
        emit(enc_br(`LA32_OP_BEQ, 5'd0, 5'd4, 16'd2));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd9, 5'd0, 12'd6));
        emit(enc_br(`LA32_OP_BNE, 5'd0, 5'd4, 16'd2));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd6, 5'd0, 12'd7));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd10, 5'd0, 12'd8));
        start_prog();
        repeat (6) expect_wb();
    endtask

    task automatic test_call();
        emit(enc_br26(`LA32_OP_BL, 26'd3));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd11, 5'd0, 12'd9));
        emit(enc_br26(`LA32_OP_B, 26'd3));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd12, 5'd0, 12'd1));
        emit(enc_br(`LA32_OP_JIRL, 5'd13, 5'd1, 16'd0)); // Return through r1.
        emit({`LA32_OP_LU12I_W, 20'h1c000, 5'd15});
        emit(enc_br(`LA32_OP_JIRL, 5'd14, 5'd15, 16'd8));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd6, 5'd0, 12'd1));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd16, 5'd0, 12'd2));
        start_prog();
        repeat (7) expect_wb();
    endtask

    task automatic test_r0();
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd0, 5'd0, 12'd77));
        emit(enc_3r(`LA32_OP_ADD_W, 5'd0, 5'd4, 5'd5));
        emit(32'h0);
        emit(enc_3r(`LA32_OP_OR, 5'd17, 5'd0, 5'd0));
        emit(enc_i12(`LA32_OP_ADDI_W, 5'd18, 5'd0, 12'd3));
        start_prog();
        repeat (2) expect_wb();
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        lfsr  = 32'd56;
        foreach (sh[i])
            sh[i] = '0;
        foreach (dmem[i]) begin
            dmem[i]     = {~16'(i * 4), 16'(i * 4)}; // Address-based fill.
            ref_dmem[i] = dmem[i];
        end
        test_alu();
        test_mem();
        test_branch();
        test_call();
        test_r0();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hdl/la32_pkg.sv
hdl/la32_decoder.sv
hdl/la32_alu.sv
hdl/la32_regfile.sv
hdl/mycpu_top.sv
test/mycpu_props.sv
test/mycpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module mycpu_tb -o mycpu_sim &&
./obj_dir/mycpu_sim | tee /dev/stderr | grep -qF "PASS: all tests" ||
{ echo "Simulation did not finish cleanly"; exit 1; }
